// File: include/vgaText_defines.svh
// VGA text display constants
// Raster timing for 640x480 at 60 Hz, text grid geometry and the bus address map
`ifndef VGATEXT_DEFINES_SVH
`define VGATEXT_DEFINES_SVH

// Horizontal timing in pixels
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// Vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

// Text grid, cells of 8 by 16 pixels
`define TEXT_COLS 80
`define TEXT_ROWS 30
`define CELL_W 8
`define CELL_H 16

// Bus word address map
`define VRAM_WORDS 600     // Four characters per word
`define CTRL_ADDR 'h258
`define GLYPH_BASE 'h400
`define GLYPH_WORDS 512    // 128 glyphs, four words each, top row in low byte
`define AVL_ADDR_W 11

`endif

// File: design/vgaTextPkg.sv
// VGA text display types
// Bus request, color, control register layout, raster position and cell load
`default_nettype none
`include "vgaText_defines.svh"

package vgaTextPkg;

    // One Avalon-MM request as the slave sees it
    typedef struct packed {
        logic                   cs;
        logic                   read;
        logic                   write;
        logic [3:0]             byteEn;
        logic [`AVL_ADDR_W-1:0] addr;       // Word address
        logic [31:0]            writeData;
    } avlReqT;

    // 12-bit color, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } colorT;

    // Control register, same bit layout as the original block
    typedef struct packed {
        logic [6:0] rsvd;      // Bits 31:25
        colorT      fgd;       // Bits 24:13
        colorT      bkg;       // Bits 12:1
        logic       vsyncTgl;  // Flips once per frame
    } ctrlRegT;

    // Beam position from the timing generator
    typedef struct packed {
        logic [9:0] x;          // Pixel within line, blanking included
        logic [9:0] y;          // Line within frame
        logic       active;
        logic [3:0] cellPhase;  // CLK count inside the 8-pixel cell
    } rasterPosT;

    // One glyph row handed from fetch to shifter
    typedef struct packed {
        logic [7:0] glyphRow;   // MSB is the leftmost pixel
        logic       inverse;
        logic       load;
    } cellLoadT;

endpackage

`default_nettype wire

// File: design/vgaTiming.sv
// Raster timing generator
// Halves CLK to the pixel rate, counts pixels and lines, and derives
// sync, blank and the beam's phase inside its character cell
`default_nettype none
`include "vgaText_defines.svh"

module vgaTiming import vgaTextPkg::*;
(
    input  wire        CLK,
    input  wire        RESET,
    output logic       pixEn,       // High on every second CLK
    output rasterPosT  pos,
    output logic       hsRaw,
    output logic       vsRaw,
    output logic       blankRaw,    // High in the visible area
    output logic       frameStart   // One CLK when vsRaw falls
);

    localparam int H_TOTAL  = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL  = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int HS_START = `H_ACTIVE + `H_FRONT;
    localparam int VS_START = `V_ACTIVE + `V_FRONT;

    logic       pixTick;   // Second CLK of the pixel when high
    logic [9:0] hCnt;
    logic [9:0] vCnt;
    logic       vsPrev;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pixTick <= 1'b0;
            hCnt    <= '0;
            vCnt    <= '0;
            vsPrev  <= 1'b1;
        end
        else
        begin
            pixTick <= ~pixTick;
            vsPrev  <= vsRaw;
            if (pixEn)
            begin
                if (hCnt == 10'(H_TOTAL - 1))
                begin
                    hCnt <= '0;
                    // Frame wrap after the back porch
                    vCnt <= (vCnt == 10'(V_TOTAL - 1)) ? '0 : vCnt + 10'd1;
                end
                else
                    hCnt <= hCnt + 10'd1;
            end
        end
    end

    assign pixEn = pixTick;

    // Both syncs active low
    assign hsRaw = !(hCnt >= 10'(HS_START) && hCnt < 10'(HS_START + `H_SYNC));
    assign vsRaw = !(vCnt >= 10'(VS_START) && vCnt < 10'(VS_START + `V_SYNC));
    assign blankRaw = (hCnt < 10'(`H_ACTIVE)) && (vCnt < 10'(`V_ACTIVE));
    assign frameStart = vsPrev && !vsRaw;

    always_comb
    begin
        pos.x         = hCnt;
        pos.y         = vCnt;
        pos.active    = blankRaw;
        pos.cellPhase = {hCnt[2:0], pixTick};  // 8 pixels of 2 CLK each
    end

    // Each hs pulse lasts exactly H_SYNC pixels
    hsWidth: assert property (@(posedge CLK) disable iff (RESET)
        $rose(hsRaw) |-> $past(!hsRaw, 2 * `H_SYNC) && $past(hsRaw, 2 * `H_SYNC + 1))
        else $error("hs pulse width is not H_SYNC pixels");

endmodule

`default_nettype wire

// File: design/cellFetchFsm.sv
// Per-cell fetch sequencer
// Runs one cell ahead of the beam: reads the VRAM word, picks the character,
// reads its glyph word and hands the glyph row to the shifter at the cell edge
`default_nettype none
`include "vgaText_defines.svh"

module cellFetchFsm import vgaTextPkg::*;
(
    input  wire                              CLK,
    input  wire                              RESET,
    input  wire rasterPosT                   pos,
    output logic [$clog2(`VRAM_WORDS)-1:0]   vramAddr,
    input  wire [31:0]                       vramData,
    output logic [$clog2(`GLYPH_WORDS)-1:0]  glyphAddr,
    input  wire [31:0]                       glyphData,
    output cellLoadT                         cellLoad
);

    localparam int VAW       = $clog2(`VRAM_WORDS);
    localparam int H_CELLS   = (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK) / `CELL_W;
    localparam int V_TOTAL   = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int ROW_WORDS = `TEXT_COLS / 4;

    typedef enum logic [1:0] {IDLE, VRAM_RD, GLYPH_RD, HOLD} fetchStateT;

    fetchStateT state;
    fetchStateT nextState;
    logic       lastCell;     // Beam in the last cell of the line
    logic [6:0] lookCol;      // Cell that starts 8 pixels later
    logic [9:0] lookY;
    logic       lookActive;
    logic [7:0] charReg;      // Character byte between the two reads

    assign lastCell = pos.x[9:3] == 7'(H_CELLS - 1);

    // Lookahead wraps into the next line, and into line 0 after the frame
    always_comb
    begin
        lookCol = pos.x[9:3] + 7'd1;
        lookY   = pos.y;
        if (lastCell)
        begin
            lookCol = '0;
            lookY   = (pos.y == 10'(V_TOTAL - 1)) ? '0 : pos.y + 10'd1;
        end
    end

    assign lookActive = lookCol < 7'(`TEXT_COLS) && lookY < 10'(`TEXT_ROWS * `CELL_H);

    // Text row times 20, plus four cells per word
    assign vramAddr  = VAW'(lookY / `CELL_H) * VAW'(ROW_WORDS) + VAW'(lookCol / 4);
    // 7-bit code picks the glyph, glyph row bits 3:2 the word
    assign glyphAddr = {charReg[6:0], lookY[3:2]};

    always_ff @(posedge CLK)
    begin
        if (RESET)
            state <= IDLE;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = state;
        case (state)
            IDLE:
            begin
                if (pos.cellPhase == 4'd2 && lookActive)
                    nextState = VRAM_RD;    // Address already on the port
            end
            VRAM_RD:  nextState = GLYPH_RD;
            GLYPH_RD: nextState = HOLD;     // Glyph RAM latches this cycle
            HOLD:
            begin
                if (pos.cellPhase == 4'd15)
                    nextState = IDLE;
            end
            default:  nextState = IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (state == VRAM_RD)
            charReg <= vramData[{lookCol[1:0], 3'b000} +: 8];  // Column mod 4
    end

    always_comb
    begin
        cellLoad.glyphRow = glyphData[{lookY[1:0], 3'b000} +: 8];
        cellLoad.inverse  = charReg[7];
        cellLoad.load     = (state == HOLD) && (pos.cellPhase == 4'd15);
    end

    // Load only at the cell edge, 13 CLK after its VRAM read began
    loadTiming: assert property (@(posedge CLK) disable iff (RESET)
        cellLoad.load |-> pos.cellPhase == 4'd15
            && $past(state == IDLE && pos.cellPhase == 4'd2, 13))
        else $error("cell load outside the fetch window");

endmodule

`default_nettype wire

// File: design/wordRam.sv
// 32-bit word RAM with byte enables
// One write port, a bus read port and a display read port, both registered
`default_nettype none

module wordRam
#(
    parameter int DEPTH = 512
)
(
    input  wire                      CLK,
    input  wire                      RESET,
    input  wire                      we,
    input  wire [3:0]                byteEn,
    input  wire [$clog2(DEPTH)-1:0]  wrAddr,
    input  wire [31:0]               wrData,
    input  wire [$clog2(DEPTH)-1:0]  rdAddrA,   // Bus side
    output logic [31:0]              rdDataA,
    input  wire [$clog2(DEPTH)-1:0]  rdAddrB,   // Display side
    output logic [31:0]              rdDataB
);

    logic [31:0] mem [DEPTH];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            mem     <= '{default: '0};   // Screen starts blank
            rdDataA <= '0;
            rdDataB <= '0;
        end
        else
        begin
            if (we)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (byteEn[b])
                        mem[wrAddr][8*b +: 8] <= wrData[8*b +: 8];  // Others keep value
                end
            end
            rdDataA <= mem[rdAddrA];
            rdDataB <= mem[rdAddrB];
        end
    end

    // Top-level decode keeps writes in range
    wrInRange: assert property (@(posedge CLK) disable iff (RESET)
        we |-> 32'(wrAddr) < DEPTH)
        else $error("write beyond RAM depth");

endmodule

`default_nettype wire

// File: design/pixelShifter.sv
// Glyph row shifter and output stage
// Shifts the row out MSB first, applies inverse and the colors,
// and registers the colors with the syncs so they stay aligned
`default_nettype none

module pixelShifter import vgaTextPkg::*;
(
    input  wire            CLK,
    input  wire            RESET,
    input  wire            pixEn,
    input  wire cellLoadT  cellLoad,
    input  wire ctrlRegT   ctrl,
    input  wire            hsIn,
    input  wire            vsIn,
    input  wire            blankIn,
    output colorT          rgb,
    output logic           hs,
    output logic           vs,
    output logic           blank
);

    logic [7:0] shiftReg;
    logic       invReg;
    logic       pixOn;      // Foreground after inverse
    colorT      pixColor;

    // Load lands on the last pixEn of the previous cell
    always_ff @(posedge CLK)
    begin
        if (cellLoad.load)
        begin
            shiftReg <= cellLoad.glyphRow;
            invReg   <= cellLoad.inverse;
        end
        else if (pixEn)
            shiftReg <= {shiftReg[6:0], 1'b0};
    end

    assign pixOn    = shiftReg[7] ^ invReg;
    assign pixColor = pixOn ? ctrl.fgd : ctrl.bkg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            rgb   <= '0;
            hs    <= 1'b1;
            vs    <= 1'b1;
            blank <= 1'b0;
        end
        else if (pixEn)
        begin
            rgb   <= blankIn ? pixColor : '0;   // Black in blanking
            hs    <= hsIn;                      // One pixel, same as rgb
            vs    <= vsIn;
            blank <= blankIn;
        end
    end

endmodule

`default_nettype wire

// File: design/vgaTextTop.sv
// VGA text display with Avalon-MM slave
// 80x30 characters from VRAM, glyphs from a loadable glyph RAM,
// colors and frame toggle in the control register, 640x480 raster out
`default_nettype none
`include "vgaText_defines.svh"

module vgaTextTop import vgaTextPkg::*;
(
    input  wire                    CLK,         // 50 MHz, shared by bus and video
    input  wire                    RESET,
    input  wire                    AVL_READ,
    input  wire                    AVL_WRITE,
    input  wire                    AVL_CS,
    input  wire [3:0]              AVL_BYTE_EN,
    input  wire [`AVL_ADDR_W-1:0]  AVL_ADDR,
    input  wire [31:0]             AVL_WRITEDATA,
    output logic [31:0]            AVL_READDATA,
    output logic [3:0]             red,
    output logic [3:0]             green,
    output logic [3:0]             blue,
    output logic                   hs,
    output logic                   vs,
    output logic                   sync,
    output logic                   blank,
    output logic                   pixel_clk
);

    localparam int AW  = `AVL_ADDR_W;
    localparam int VAW = $clog2(`VRAM_WORDS);
    localparam int GAW = $clog2(`GLYPH_WORDS);

    avlReqT          avlReq;
    logic            wrEn, rdEn;
    logic            isVram, isCtrl, isGlyph;
    logic [2:0]      rdSel;         // {glyph, ctrl, vram} of the pending read
    ctrlRegT         ctrlReg;
    logic [31:0]     vramRdData, glyphRdData;
    logic [VAW-1:0]  vramDispAddr;
    logic [GAW-1:0]  glyphDispAddr;
    logic [31:0]     vramDispData, glyphDispData;
    logic            pixEn, hsRaw, vsRaw, blankRaw, frameStart;
    rasterPosT       pos;
    cellLoadT        cellLoad;
    colorT           rgb;

    always_comb
    begin
        avlReq.cs        = AVL_CS;
        avlReq.read      = AVL_READ;
        avlReq.write     = AVL_WRITE;
        avlReq.byteEn    = AVL_BYTE_EN;
        avlReq.addr      = AVL_ADDR;
        avlReq.writeData = AVL_WRITEDATA;
    end

    assign wrEn    = avlReq.cs && avlReq.write;
    assign rdEn    = avlReq.cs && avlReq.read;
    assign isVram  = avlReq.addr < AW'(`VRAM_WORDS);
    assign isCtrl  = avlReq.addr == AW'(`CTRL_ADDR);
    assign isGlyph = avlReq.addr >= AW'(`GLYPH_BASE)
                     && avlReq.addr < AW'(`GLYPH_BASE + `GLYPH_WORDS);

    always_ff @(posedge CLK)
    begin
        if (RESET)
            ctrlReg <= '0;
        else
        begin
            if (wrEn && isCtrl)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (avlReq.byteEn[b])
                        ctrlReg[8*b +: 8] <= avlReq.writeData[8*b +: 8];
                end
            end
            // Bit 0 is owned by the frame toggle
            ctrlReg.vsyncTgl <= ctrlReg.vsyncTgl ^ frameStart;
        end
    end

    // Decode held one cycle for the read data mux
    always_ff @(posedge CLK)
    begin
        if (RESET)
            rdSel <= '0;
        else
            rdSel <= rdEn ? {isGlyph, isCtrl, isVram} : 3'b000;
    end

    always_comb
    begin
        AVL_READDATA = '0;    // Unmapped or idle
        if (rdSel[0])
            AVL_READDATA = vramRdData;
        else if (rdSel[1])
            AVL_READDATA = ctrlReg;
        else if (rdSel[2])
            AVL_READDATA = glyphRdData;
    end

    vgaTiming timingInst
    (
        .CLK,
        .RESET,
        .pixEn,
        .pos,
        .hsRaw,
        .vsRaw,
        .blankRaw,
        .frameStart
    );

    cellFetchFsm fetchInst
    (
        .CLK,
        .RESET,
        .pos,
        .vramAddr  (vramDispAddr),
        .vramData  (vramDispData),
        .glyphAddr (glyphDispAddr),
        .glyphData (glyphDispData),
        .cellLoad
    );

    wordRam #(.DEPTH(`VRAM_WORDS)) vramInst
    (
        .CLK,
        .RESET,
        .we      (wrEn && isVram),
        .byteEn  (avlReq.byteEn),
        .wrAddr  (avlReq.addr[VAW-1:0]),
        .wrData  (avlReq.writeData),
        .rdAddrA (avlReq.addr[VAW-1:0]),
        .rdDataA (vramRdData),
        .rdAddrB (vramDispAddr),
        .rdDataB (vramDispData)
    );

    // Base is aligned, so the low bits are the glyph word offset
    wordRam #(.DEPTH(`GLYPH_WORDS)) glyphInst
    (
        .CLK,
        .RESET,
        .we      (wrEn && isGlyph),
        .byteEn  (avlReq.byteEn),
        .wrAddr  (avlReq.addr[GAW-1:0]),
        .wrData  (avlReq.writeData),
        .rdAddrA (avlReq.addr[GAW-1:0]),
        .rdDataA (glyphRdData),
        .rdAddrB (glyphDispAddr),
        .rdDataB (glyphDispData)
    );

    pixelShifter shifterInst
    (
        .CLK,
        .RESET,
        .pixEn,
        .cellLoad,
        .ctrl    (ctrlReg),
        .hsIn    (hsRaw),
        .vsIn    (vsRaw),
        .blankIn (blankRaw),
        .rgb,
        .hs,
        .vs,
        .blank
    );

    assign red       = rgb.r;
    assign green     = rgb.g;
    assign blue      = rgb.b;
    assign sync      = 1'b0;    // No sync on green
    assign pixel_clk = pixEn;   // Falls on the edge where outputs update

endmodule

`default_nettype wire

// File: tb/vgaTextTb.sv
// Testbench for the VGA text display
// Loads VRAM, glyphs and colors over the Avalon bus with read-back,
// then watches the raster and compares every pixel of one frame with a model
`default_nettype none
`include "vgaText_defines.svh"

module vgaTextTb import vgaTextPkg::*;;

    localparam int FRAME_TIME = 800 * 525 * 2 * 20;        // 2 CLK per pixel
    localparam int TIMEOUT    = 2 * FRAME_TIME + 6400000;  // Two frames plus bus phase
    localparam int ROW_WORDS  = `TEXT_COLS / 4;

    logic        CLK;
    logic        RESET;
    logic        AVL_READ, AVL_WRITE, AVL_CS;
    logic [3:0]  AVL_BYTE_EN;
    logic [10:0] AVL_ADDR;
    logic [31:0] AVL_WRITEDATA;
    wire [31:0]  AVL_READDATA;
    wire [3:0]   red, green, blue;
    wire         hs, vs, sync, blank, pixel_clk;

    logic [15:0] lfsr;
    logic [31:0] vramModel [`VRAM_WORDS];
    logic [31:0] glyphModel [`GLYPH_WORDS];
    ctrlRegT     ctrlModel;

    // Values latched on the falling edge, checked on the next rising edge
    logic        readChk, resetChk, pixChk, lineChk, frameChk;
    logic [10:0] readAddr;
    logic [31:0] readGot, readExp;
    logic [11:0] pixGot, pixExp;
    int          pixCol, pixRow;
    int          gotLineLen, gotHsLow, gotBlankCnt;
    int          gotLines, gotVsLines, gotActiveLines;

    logic        started;
    logic        prevHs, prevVs;
    int          lineLen, hsLowCnt, blankCnt, linesSeen;
    int          lineCount, vsLowLines, activeLines, activeRow, vsFalls;

    vgaTextTop vgaTextTop_inst
    (
        .CLK, .RESET, .AVL_READ, .AVL_WRITE, .AVL_CS, .AVL_BYTE_EN, .AVL_ADDR,
        .AVL_WRITEDATA, .AVL_READDATA, .red, .green, .blue, .hs, .vs, .sync,
        .blank, .pixel_clk
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic reportFail(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    initial
    begin
        #(TIMEOUT);
        reportFail("Timeout: the raster checks did not complete in time");
    end

    // Galois LFSR, one step per random bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        lsb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb)
                lfsr = lfsr ^ 16'hB400;
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] be);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++)
            if (be[b])
                r[8*b +: 8] = data[8*b +: 8];
        return r;
    endfunction

    function automatic logic [31:0] modelRead(input logic [10:0] addr);
        if (addr < `VRAM_WORDS)
            return vramModel[addr];
        if (addr == `CTRL_ADDR)
            return ctrlModel;
        if (addr >= `GLYPH_BASE && addr < `GLYPH_BASE + `GLYPH_WORDS)
            return glyphModel[addr - `GLYPH_BASE];
        return '0;    // Unmapped
    endfunction

    // Color of one visible pixel from the model contents
    function automatic logic [11:0] expectedPixel(input int col, input int row);
        int          cx;
        int          cy;
        logic [31:0] word;
        logic [7:0]  ch;
        logic [31:0] gw;
        logic [7:0]  rowBits;
        logic        on;
        cx      = col / `CELL_W;
        cy      = row / `CELL_H;
        word    = vramModel[cy * ROW_WORDS + cx / 4];
        ch      = word[8 * (cx % 4) +: 8];
        gw      = glyphModel[int'(ch[6:0]) * 4 + (row % `CELL_H) / 4];
        rowBits = gw[8 * (row % 4) +: 8];
        on      = rowBits[7 - col % `CELL_W] ^ ch[7];   // MSB is leftmost
        return on ? ctrlModel.fgd : ctrlModel.bkg;
    endfunction

    task automatic busWrite(input logic [10:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
        logic [31:0] merged;
        @(negedge CLK);
        AVL_CS = 1'b1;
        AVL_WRITE = 1'b1;
        AVL_ADDR = addr;
        AVL_WRITEDATA = data;
        AVL_BYTE_EN = be;
        @(negedge CLK);
        AVL_CS = 1'b0;
        AVL_WRITE = 1'b0;
        if (addr < `VRAM_WORDS)
            vramModel[addr] = mergeBytes(vramModel[addr], data, be);
        else if (addr == `CTRL_ADDR)
        begin
            merged    = mergeBytes(ctrlModel, data, be);
            merged[0] = ctrlModel.vsyncTgl;   // Toggle bit not writable
            ctrlModel = merged;
        end
        else if (addr >= `GLYPH_BASE && addr < `GLYPH_BASE + `GLYPH_WORDS)
            glyphModel[addr - `GLYPH_BASE] = mergeBytes(glyphModel[addr - `GLYPH_BASE], data, be);
    endtask

    task automatic busRead(input logic [10:0] addr);
        @(negedge CLK);
        AVL_CS = 1'b1;
        AVL_READ = 1'b1;
        AVL_ADDR = addr;
        @(negedge CLK);
        readGot  = AVL_READDATA;   // One cycle after the read
        AVL_CS = 1'b0;
        AVL_READ = 1'b0;
        readAddr = addr;
        readExp  = modelRead(addr);
        readChk  = 1'b1;
        @(negedge CLK);
        readChk  = 1'b0;
    endtask

    task automatic writeThenRead(input logic [10:0] addr);
        logic [31:0] data;
        logic [3:0]  be;
        data = randBits(32);
        be   = 4'(randBits(4));
        busWrite(addr, data, be);
        busRead(addr);
    endtask

    // Raster observer, samples while pixel_clk is high
    always @(negedge CLK)
    begin
        pixChk   = 1'b0;
        lineChk  = 1'b0;
        frameChk = 1'b0;
        if (started && pixel_clk)
        begin
            if (prevVs && !vs)
            begin
                if (vsFalls > 0)
                begin
                    gotLines       = lineCount;
                    gotVsLines     = vsLowLines;
                    gotActiveLines = activeLines;
                    frameChk       = 1'b1;
                end
                lineCount   = 0;
                vsLowLines  = 0;
                activeLines = 0;
                activeRow   = 0;
                vsFalls++;
            end
            if (prevHs && !hs)
            begin
                if (linesSeen > 0)
                begin
                    gotLineLen  = lineLen;
                    gotHsLow    = hsLowCnt;
                    gotBlankCnt = blankCnt;
                    lineChk     = 1'b1;
                end
                if (blankCnt > 0)
                begin
                    activeRow++;
                    activeLines++;
                end
                lineCount++;
                if (!vs)
                    vsLowLines++;
                lineLen  = 0;
                hsLowCnt = 0;
                blankCnt = 0;
                linesSeen++;
            end
            lineLen++;
            if (!hs)
                hsLowCnt++;
            pixGot = {red, green, blue};
            if (blank)
            begin
                pixCol = blankCnt;
                pixRow = activeRow;
                pixExp = expectedPixel(blankCnt, activeRow);
                pixChk = vsFalls >= 1;    // Frame 0 overlaps the bus phase
                blankCnt++;
            end
            else
            begin
                pixExp = '0;
                pixChk = 1'b1;
            end
            prevHs = hs;
            prevVs = vs;
        end
    end

    readCheck: assert property (@(posedge CLK) readChk |-> readGot == readExp)
        else reportFail($sformatf("Mismatch at %0t: read of address %h returned %h, expected %h",
                                  $time, readAddr, readGot, readExp));

    resetCheck: assert property (@(posedge CLK) resetChk |->
        hs && vs && !blank && {red, green, blue} == 12'h0 && AVL_READDATA == '0)
        else reportFail($sformatf("Mismatch at %0t: outputs not at reset values", $time));

    syncCheck: assert property (@(posedge CLK) started |-> !sync)
        else reportFail($sformatf("Mismatch at %0t: sync is %b, expected 0", $time, sync));

    pixelCheck: assert property (@(posedge CLK) pixChk |-> pixGot == pixExp)
        else reportFail($sformatf("Mismatch at %0t: pixel %0d,%0d is %h, expected %h",
                                  $time, pixCol, pixRow, pixGot, pixExp));

    lineCheck: assert property (@(posedge CLK) lineChk |-> gotLineLen == 800
        && gotHsLow == `H_SYNC && (gotBlankCnt == 0 || gotBlankCnt == `H_ACTIVE))
        else reportFail($sformatf("Mismatch at %0t: line of %0d pixels, hs low %0d, blank %0d",
                                  $time, gotLineLen, gotHsLow, gotBlankCnt));

    frameCheck: assert property (@(posedge CLK) frameChk |-> gotLines == 525
        && gotVsLines == `V_SYNC && gotActiveLines == `V_ACTIVE)
        else reportFail($sformatf("Mismatch at %0t: frame of %0d lines, vs %0d, active %0d",
                                  $time, gotLines, gotVsLines, gotActiveLines));

    initial
    begin
        RESET = 1'b1;
        AVL_READ = 1'b0;
        AVL_WRITE = 1'b0;
        AVL_CS = 1'b0;
        AVL_BYTE_EN = '0;
        AVL_ADDR = '0;
        AVL_WRITEDATA = '0;
        lfsr = 16'd42779;
        ctrlModel = '0;
        readChk = 1'b0;
        resetChk = 1'b0;
        started = 1'b0;
        prevHs = 1'b1;
        prevVs = 1'b1;
        {lineLen, hsLowCnt, blankCnt, linesSeen} = '0;
        {lineCount, vsLowLines, activeLines, activeRow, vsFalls} = '0;
        for (int i = 0; i < `VRAM_WORDS; i++)
            vramModel[i] = '0;
        for (int i = 0; i < `GLYPH_WORDS; i++)
            glyphModel[i] = '0;

        @(posedge CLK);
        @(negedge CLK);
        resetChk = 1'b1;             // Mid reset, outputs settled
        @(posedge CLK);
        @(negedge CLK);
        resetChk = 1'b0;
        RESET = 1'b0;
        started = 1'b1;

        for (int a = 0; a < `VRAM_WORDS; a++)
            writeThenRead(11'(a));
        for (int g = 0; g < `GLYPH_WORDS; g++)
            writeThenRead(11'(`GLYPH_BASE + g));
        for (int k = 0; k < 4; k++)
            writeThenRead(11'(`CTRL_ADDR));
        busWrite(11'(`CTRL_ADDR), randBits(32), 4'hF);
        busRead(11'(`CTRL_ADDR));    // Toggle still clear
        busRead(11'(`CTRL_ADDR + 1));
        busRead(11'h3FF);
        busRead(11'h600);
        busRead(11'h7FF);

        while (vsFalls < 1)
            @(negedge CLK);
        ctrlModel.vsyncTgl = 1'b1;   // One vs pulse seen
        busRead(11'(`CTRL_ADDR));

        while (vsFalls < 2)
            @(negedge CLK);
        repeat (4) @(negedge CLK);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
design/vgaTextPkg.sv
design/vgaTiming.sv
design/cellFetchFsm.sv
design/wordRam.sv
design/pixelShifter.sv
design/vgaTextTop.sv
tb/vgaTextTb.sv

// File: run.sh
#!/bin/sh
# Build the VGA text display testbench with Verilator, run it, check the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vgaTextTb \
    -f flist.f -o vgaTextSim || exit 1
./obj_dir/vgaTextSim > sim.log 2>&1 || true
cat sim.log
test -s sim.log || { echo "No simulation log"; exit 1; }
grep -q "Testbench failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || echo "Simulation finished without failure"
